//--- Makefile
# Verilator build, run and lint for the board control block

VERILATOR ?= verilator
TB_TOP    ?= board_tb
RTL_TOP   ?= board_top
FILELIST  ?= board_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- board_top.f
+incdir+hdl
hdl/board_pkg.sv
hdl/board_rst_sync.sv
hdl/rtc_divider.sv
hdl/fan_pwm_ctrl.sv
hdl/board_regs.sv
hdl/board_top.sv
dv/board_tb.sv

//--- dv/board_tb.sv
// Board control testbench
`include "board_settings.svh"

module board_tb;

  localparam int clk_period = 20;
  localparam int pwm_period = 16 * `FAN_PRESCALE;
  localparam int ack_limit  = 16;
  localparam int edge_limit = 3 * `RTC_HALF_PERIOD;

  // Cycle budget of all sections plus half again for the watchdog
  localparam int n_access      = 200;
  localparam int access_cycles = 8;
  localparam int n_duty        = 6;
  localparam int test_cycles   = 20 + n_access * access_cycles
                                 + n_duty * 3 * pwm_period
                                 + 2 * (10 * `RTC_HALF_PERIOD + 200);
  localparam int watchdog_time = test_cycles * clk_period * 3 / 2;

  logic                  soc_clk = 1'b0;
  logic                  rst_n;
  logic                  test_mode_i;
  logic                  host_req_i;
  logic                  host_we_i;
  board_pkg::reg_addr_t  host_addr_i;
  board_pkg::reg_data_t  host_wdata_i;
  logic                  host_ack_o;
  board_pkg::reg_data_t  host_rdata_o;
  board_pkg::fan_duty_t  fan_sw_i;
  board_pkg::boot_mode_t boot_mode_i;
  board_pkg::boot_mode_t boot_mode_o;
  logic                  rtc_clk_o;
  logic                  fan_pwm_o;

  // Reference model of the register contents
  logic [2:0]            m_ctrl;
  board_pkg::fan_duty_t  m_fan;
  board_pkg::boot_mode_t m_boot;
  logic [31:0]           rng_state;

  board_top u_dut (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( rst_n        ),
    .test_mode_i  ( test_mode_i  ),
    .host_req_i   ( host_req_i   ),
    .host_we_i    ( host_we_i    ),
    .host_addr_i  ( host_addr_i  ),
    .host_wdata_i ( host_wdata_i ),
    .host_ack_o   ( host_ack_o   ),
    .host_rdata_o ( host_rdata_o ),
    .fan_sw_i     ( fan_sw_i     ),
    .boot_mode_i  ( boot_mode_i  ),
    .boot_mode_o  ( boot_mode_o  ),
    .rtc_clk_o    ( rtc_clk_o    ),
    .fan_pwm_o    ( fan_pwm_o    )
  );

  initial begin
    forever #(clk_period / 2) soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {8'd0, rng_state[31:8]};
  endfunction

  task automatic stop_failed();
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input board_pkg::reg_data_t exp,
                            input board_pkg::reg_data_t act);
    if (act !== exp) begin
      $display("[FAIL] time %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_boot(input string name, input board_pkg::boot_mode_t exp,
                            input board_pkg::boot_mode_t act);
    if (act !== exp) begin
      $display("[FAIL] time %0t: %s expected %0d, got %0d", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_duty(input string name, input board_pkg::fan_duty_t exp,
                            input board_pkg::fan_duty_t act);
    if (act !== exp) begin
      $display("[FAIL] time %0t: %s expected %0d, got %0d", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] time %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] time %0t: %s expected %0d, got %0d", $time, name, exp, act);
      stop_failed();
    end
  endtask

  function automatic board_pkg::reg_data_t model_read(input board_pkg::reg_addr_t addr);
    case (addr)
      `REG_ID:   return `BOARD_ID;
      `REG_CTRL: return {5'b0, m_ctrl};
      `REG_FAN:  return {4'b0, m_fan};
      `REG_BOOT: return {6'b0, m_boot};
      default:   return '0;
    endcase
  endfunction

  // ID is read only and SOFT_RST and unmapped addresses hold nothing
  task automatic model_write(input board_pkg::reg_addr_t addr,
                             input board_pkg::reg_data_t data);
    case (addr)
      `REG_CTRL: m_ctrl = data[2:0];
      `REG_FAN:  m_fan  = data[3:0];
      `REG_BOOT: m_boot = data[1:0];
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Host port
  ////////////////////////////////////////////////////////////

  task automatic host_access(input logic we, input board_pkg::reg_addr_t addr,
                             input board_pkg::reg_data_t wdata,
                             output board_pkg::reg_data_t rdata);
    int waited;
    @(posedge soc_clk);
    host_req_i   <= 1'b1;
    host_we_i    <= we;
    host_addr_i  <= addr;
    host_wdata_i <= wdata;
    waited = 0;
    do begin
      @(negedge soc_clk);
      waited++;
    end while (!host_ack_o && waited < ack_limit);
    if (!host_ack_o) begin
      $display("Host request to address %0d was never acknowledged", addr);
      stop_failed();
    end
    // Req is seen on the first edge and ack shows after the second
    check_count("host_ack_o latency", 2, waited);
    rdata = host_rdata_o;
    @(posedge soc_clk);
    host_req_i <= 1'b0;
    waited = 0;
    do begin
      @(negedge soc_clk);
      waited++;
    end while (host_ack_o && waited < ack_limit);
    if (host_ack_o) begin
      $display("host_ack_o stayed high after the request was dropped");
      stop_failed();
    end
    // Ack drops on the edge after req is seen low
    check_count("host_ack_o release", 2, waited);
  endtask

  task automatic write_reg(input board_pkg::reg_addr_t addr, input board_pkg::reg_data_t data);
    board_pkg::reg_data_t ignored;
    host_access(1'b1, addr, data, ignored);
    model_write(addr, data);
  endtask

  task automatic read_and_compare(input board_pkg::reg_addr_t addr);
    board_pkg::reg_data_t rdata;
    host_access(1'b0, addr, '0, rdata);
    check_data($sformatf("host_rdata_o at address %0d", addr), model_read(addr), rdata);
  endtask

  ////////////////////////////////////////////////////////////
  // Board outputs
  ////////////////////////////////////////////////////////////

  task automatic outputs_idle();
    check_bit("host_ack_o", 1'b0, host_ack_o);
    check_bit("rtc_clk_o", 1'b0, rtc_clk_o);
    check_bit("fan_pwm_o", 1'b0, fan_pwm_o);
  endtask

  // Override picks the BOOT register over the switches
  task automatic drive_boot_switches(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = next_rand();
      @(posedge soc_clk);
      boot_mode_i <= r[1:0];
      @(negedge soc_clk);
      check_boot("boot_mode_o", m_ctrl[2] ? m_boot : r[1:0], boot_mode_o);
    end
  endtask

  task automatic measure_fan(input board_pkg::fan_duty_t duty);
    int high;
    high = 0;
    // Let the new duty pass the switch register and a period boundary
    repeat (2 * pwm_period) @(negedge soc_clk);
    repeat (pwm_period) begin
      @(negedge soc_clk);
      if (fan_pwm_o) begin
        high++;
      end
    end
    check_duty("fan_pwm_o duty", duty, board_pkg::fan_duty_t'(high / `FAN_PRESCALE));
    check_count("fan_pwm_o high cycles", int'(duty) * `FAN_PRESCALE, high);
  endtask

  task automatic check_rtc_halves(input int halves);
    logic level;
    int   n;
    // The first edge only marks where counting starts
    level = rtc_clk_o;
    n = 0;
    while (rtc_clk_o == level && n < edge_limit) begin
      @(negedge soc_clk);
      n++;
    end
    if (rtc_clk_o == level) begin
      $display("rtc_clk_o did not toggle within %0d cycles", edge_limit);
      stop_failed();
    end
    repeat (halves) begin
      level = rtc_clk_o;
      n = 0;
      do begin
        @(negedge soc_clk);
        n++;
      end while (rtc_clk_o == level && n < edge_limit);
      check_count("rtc_clk_o half period", `RTC_HALF_PERIOD, n);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]          r;
    board_pkg::reg_addr_t waddr;
    int                   n;
    rng_state = 32'd21454;
    m_ctrl    = 3'b001;
    m_fan     = '0;
    m_boot    = '0;
    rst_n        <= 1'b0;
    test_mode_i  <= 1'b0;
    host_req_i   <= 1'b0;
    host_we_i    <= 1'b0;
    host_addr_i  <= '0;
    host_wdata_i <= '0;
    fan_sw_i     <= '0;
    boot_mode_i  <= '0;

    // Reset state
    repeat (2) begin
      @(negedge soc_clk);
      outputs_idle();
    end
    @(posedge soc_clk);
    rst_n <= 1'b1;
    repeat (`RST_SYNC_STAGES + 2) begin
      @(negedge soc_clk);
      outputs_idle();
    end
    read_and_compare(`REG_ID);
    read_and_compare(`REG_CTRL);
    drive_boot_switches(4);

    // Random register traffic with reads often at the address just written
    repeat (60) begin
      r = next_rand();
      waddr = r[3:0];
      write_reg(waddr, r[15:8]);
      read_and_compare(r[16] ? waddr : r[23:20]);
    end

    // Boot override on and then off
    write_reg(`REG_CTRL, 8'h05);
    r = next_rand();
    write_reg(`REG_BOOT, {6'b0, r[1:0]});
    drive_boot_switches(4);
    write_reg(`REG_CTRL, 8'h01);
    drive_boot_switches(4);

    // Fan duty from the switches and then from the FAN register
    repeat (n_duty / 2) begin
      r = next_rand();
      @(posedge soc_clk);
      fan_sw_i <= r[3:0];
      measure_fan(r[3:0]);
    end
    write_reg(`REG_CTRL, 8'h03);
    repeat (n_duty / 2) begin
      r = next_rand();
      write_reg(`REG_FAN, {4'b0, r[3:0]});
      @(posedge soc_clk);
      fan_sw_i <= r[7:4];
      measure_fan(r[3:0]);
    end

    // RTC period and then parked low while disabled
    write_reg(`REG_CTRL, 8'h01);
    check_rtc_halves(4);
    write_reg(`REG_CTRL, 8'h00);
    repeat (200) begin
      @(negedge soc_clk);
      check_bit("rtc_clk_o", 1'b0, rtc_clk_o);
    end

    // Soft reset keeps the registers and restarts the RTC
    r = next_rand();
    write_reg(`REG_CTRL, {5'b0, r[1:0], 1'b1});
    write_reg(`REG_FAN, {4'b0, r[7:4]});
    write_reg(`REG_BOOT, {6'b0, r[9:8]});
    n = 0;
    while (!rtc_clk_o && n < 2 * edge_limit) begin
      @(negedge soc_clk);
      n++;
    end
    check_bit("rtc_clk_o", 1'b1, rtc_clk_o);
    write_reg(`REG_SOFT_RST, 8'h01);
    check_bit("rtc_clk_o", 1'b0, rtc_clk_o);
    read_and_compare(`REG_CTRL);
    read_and_compare(`REG_FAN);
    read_and_compare(`REG_BOOT);
    check_rtc_halves(3);

    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("Watchdog expired after %0d time units, the run did not finish", watchdog_time);
    stop_failed();
  end

endmodule

//--- hdl/board_pkg.sv
// Board control types
package board_pkg;

  ////////////////////////////////////////////////////////////
  // Host port
  ////////////////////////////////////////////////////////////

  // Register address and data on the req/ack port
  typedef logic [3:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  ////////////////////////////////////////////////////////////
  // Board controls
  ////////////////////////////////////////////////////////////

  // Fan duty in sixteenths of a PWM period
  typedef logic [3:0] fan_duty_t;

  // Boot mode handed to the SoC
  typedef logic [1:0] boot_mode_t;

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  // Four-phase req/ack states
  typedef enum logic [1:0] {
    HS_IDLE,
    HS_ACK,
    HS_DONE
  } hs_state_t;

endpackage

//--- hdl/board_regs.sv
// Board control registers
`include "board_settings.svh"

module board_regs (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  // Host req/ack port
  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  board_pkg::reg_addr_t  host_addr_i,
  input  board_pkg::reg_data_t  host_wdata_i,
  output logic                  host_ack_o,
  output board_pkg::reg_data_t  host_rdata_o,
  // Board switches
  input  board_pkg::fan_duty_t  fan_sw_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  // Controls to the rest of the board
  output board_pkg::boot_mode_t boot_mode_o,
  output board_pkg::fan_duty_t  fan_duty_o,
  output logic                  rtc_en_o,
  output logic                  soft_rst_o
);

  // CTRL bit positions
  localparam int ctrl_rtc_en    = 0;
  localparam int ctrl_fan_ovr   = 1;
  localparam int ctrl_boot_ovr  = 2;

  board_pkg::hs_state_t  state_q;
  board_pkg::hs_state_t  state_d;
  logic                  ack_q;
  logic                  access;
  logic                  wr_en;

  logic [2:0]            ctrl_q;
  board_pkg::fan_duty_t  fan_q;
  board_pkg::fan_duty_t  fan_sw_q;
  board_pkg::boot_mode_t boot_q;
  logic                  soft_rst_q;
  board_pkg::reg_data_t  rd_data;
  board_pkg::reg_data_t  rdata_q;

  ////////////////////////////////////////////////////////////
  // Four-phase handshake
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      board_pkg::HS_IDLE: begin
        if (host_req_i) begin
          state_d = board_pkg::HS_ACK;
        end
      end
      board_pkg::HS_ACK: begin
        // Hold ack until the host lets go of req
        if (!host_req_i) begin
          state_d = board_pkg::HS_DONE;
        end
      end
      board_pkg::HS_DONE: begin
        state_d = board_pkg::HS_IDLE;
      end
      default: begin
        state_d = board_pkg::HS_IDLE;
      end
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= board_pkg::HS_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= (state_d == board_pkg::HS_ACK);
    end
  end

  // The access happens on the edge that raises ack
  assign access = (state_q == board_pkg::HS_IDLE) && host_req_i;
  assign wr_en  = access && host_we_i;

  ////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q     <= 3'b001;
      fan_q      <= '0;
      boot_q     <= '0;
      fan_sw_q   <= '0;
      soft_rst_q <= 1'b0;
    end else begin
      fan_sw_q   <= fan_sw_i;
      soft_rst_q <= 1'b0;
      if (wr_en) begin
        case (host_addr_i)
          `REG_CTRL:     ctrl_q     <= host_wdata_i[2:0];
          `REG_FAN:      fan_q      <= host_wdata_i[3:0];
          `REG_BOOT:     boot_q     <= host_wdata_i[1:0];
          `REG_SOFT_RST: soft_rst_q <= host_wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Register reads
  ////////////////////////////////////////////////////////////

  // SOFT_RST and unmapped addresses read zero
  always_comb begin
    case (host_addr_i)
      `REG_ID:   rd_data = `BOARD_ID;
      `REG_CTRL: rd_data = {5'b0, ctrl_q};
      `REG_FAN:  rd_data = {4'b0, fan_q};
      `REG_BOOT: rd_data = {6'b0, boot_q};
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge soc_clk) begin
    if (access && !host_we_i) begin
      rdata_q <= rd_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign host_ack_o   = ack_q;
  assign host_rdata_o = rdata_q;

  // Overrides pick the register over the board switches
  assign fan_duty_o  = ctrl_q[ctrl_fan_ovr] ? fan_q : fan_sw_q;
  assign boot_mode_o = ctrl_q[ctrl_boot_ovr] ? boot_q : boot_mode_i;
  assign rtc_en_o    = ctrl_q[ctrl_rtc_en];
  assign soft_rst_o  = soft_rst_q;

endmodule

//--- hdl/board_rst_sync.sv
// Board reset synchronizer
`include "board_settings.svh"

module board_rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  input  logic soft_rst_i,
  output logic board_rst_n_o,
  output logic periph_rst_n_o
);

  localparam int stages = `RST_SYNC_STAGES;

  logic [stages-1:0] board_q;
  logic [stages-1:0] periph_q;

  // Board chain, asserts with rst_n and releases after the stage count
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      board_q <= '0;
    end else begin
      board_q <= {board_q[stages-2:0], 1'b1};
    end
  end

  // Peripheral chain, also restarted by the soft reset pulse
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      periph_q <= '0;
    end else if (soft_rst_i) begin
      periph_q <= '0;
    end else begin
      periph_q <= {periph_q[stages-2:0], 1'b1};
    end
  end

  // Test mode hands the raw reset straight through
  assign board_rst_n_o  = test_mode_i ? rst_n : board_q[stages-1];
  assign periph_rst_n_o = test_mode_i ? rst_n : periph_q[stages-1];

endmodule

//--- hdl/board_settings.svh
// Board control settings
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Clock dividers
////////////////////////////////////////////////////////////

// soc_clk cycles per RTC half period (50 MHz down to 1 MHz)
`define RTC_HALF_PERIOD 25

// soc_clk cycles per PWM step, small for simulation
`define FAN_PRESCALE 4

////////////////////////////////////////////////////////////
// Board identity and reset
////////////////////////////////////////////////////////////

`define BOARD_ID 8'hC5
`define RST_SYNC_STAGES 2

////////////////////////////////////////////////////////////
// Host register map
////////////////////////////////////////////////////////////

`define REG_ID       4'd0
`define REG_CTRL     4'd1
`define REG_FAN      4'd2
`define REG_BOOT     4'd3
`define REG_SOFT_RST 4'd4

`endif

//--- hdl/board_top.sv
// Board control top level
module board_top (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  test_mode_i,
  // Host req/ack port
  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  board_pkg::reg_addr_t  host_addr_i,
  input  board_pkg::reg_data_t  host_wdata_i,
  output logic                  host_ack_o,
  output board_pkg::reg_data_t  host_rdata_o,
  // Board switches
  input  board_pkg::fan_duty_t  fan_sw_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  // Board outputs
  output board_pkg::boot_mode_t boot_mode_o,
  output logic                  rtc_clk_o,
  output logic                  fan_pwm_o
);

  logic                 board_rst_n;
  logic                 periph_rst_n;
  logic                 soft_rst;
  logic                 rtc_en;
  board_pkg::fan_duty_t fan_duty;

  ////////////////////////////////////////////////////////////
  // Reset
  ////////////////////////////////////////////////////////////

  board_rst_sync u_rst_sync (
    .soc_clk        ( soc_clk      ),
    .rst_n          ( rst_n        ),
    .test_mode_i    ( test_mode_i  ),
    .soft_rst_i     ( soft_rst     ),
    .board_rst_n_o  ( board_rst_n  ),
    .periph_rst_n_o ( periph_rst_n )
  );

  ////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////

  // Kept on the board reset so a soft reset leaves settings alone
  board_regs u_regs (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( board_rst_n  ),
    .host_req_i   ( host_req_i   ),
    .host_we_i    ( host_we_i    ),
    .host_addr_i  ( host_addr_i  ),
    .host_wdata_i ( host_wdata_i ),
    .host_ack_o   ( host_ack_o   ),
    .host_rdata_o ( host_rdata_o ),
    .fan_sw_i     ( fan_sw_i     ),
    .boot_mode_i  ( boot_mode_i  ),
    .boot_mode_o  ( boot_mode_o  ),
    .fan_duty_o   ( fan_duty     ),
    .rtc_en_o     ( rtc_en       ),
    .soft_rst_o   ( soft_rst     )
  );

  ////////////////////////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////////////////////////

  // 1 MHz RTC for the SoC
  rtc_divider u_rtc (
    .soc_clk   ( soc_clk      ),
    .rst_n     ( periph_rst_n ),
    .rtc_en_i  ( rtc_en       ),
    .rtc_clk_o ( rtc_clk_o    )
  );

  fan_pwm_ctrl u_fan (
    .soc_clk   ( soc_clk      ),
    .rst_n     ( periph_rst_n ),
    .duty_i    ( fan_duty     ),
    .fan_pwm_o ( fan_pwm_o    )
  );

endmodule

//--- hdl/fan_pwm_ctrl.sv
// Fan PWM controller
`include "board_settings.svh"

module fan_pwm_ctrl (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  board_pkg::fan_duty_t duty_i,
  output logic                 fan_pwm_o
);

  localparam int pre_w = $clog2(`FAN_PRESCALE);

  ////////////////////////////////////////////////////////////
  // Step timing
  ////////////////////////////////////////////////////////////

  logic [pre_w-1:0]     pre_q;
  logic [pre_w-1:0]     pre_d;
  board_pkg::fan_duty_t step_q;
  board_pkg::fan_duty_t step_d;
  board_pkg::fan_duty_t duty_q;
  board_pkg::fan_duty_t duty_d;
  logic                 pwm_q;
  logic                 pwm_d;

  always_comb begin
    pre_d  = pre_q + 1'b1;
    step_d = step_q;
    duty_d = duty_q;
    if (pre_q == pre_w'(`FAN_PRESCALE - 1)) begin
      pre_d  = '0;
      step_d = step_q + 1'b1;
      // Last step of the period, take the new duty
      if (step_q == 4'd15) begin
        duty_d = duty_i;
      end
    end
    // Output lines up with the step it belongs to
    pwm_d = (step_d < duty_d);
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q  <= '0;
      step_q <= '0;
      duty_q <= '0;
      pwm_q  <= 1'b0;
    end else begin
      pre_q  <= pre_d;
      step_q <= step_d;
      duty_q <= duty_d;
      pwm_q  <= pwm_d;
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- hdl/rtc_divider.sv
// Real-time clock divider
`include "board_settings.svh"

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic rtc_en_i,
  output logic rtc_clk_o
);

  localparam int cnt_w = $clog2(`RTC_HALF_PERIOD);

  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] cnt_d;
  logic             rtc_clk_q;
  logic             rtc_clk_d;

  // Count one half period, then flip the output
  always_comb begin
    cnt_d     = cnt_q + 1'b1;
    rtc_clk_d = rtc_clk_q;
    if (cnt_q == cnt_w'(`RTC_HALF_PERIOD - 1)) begin
      cnt_d     = '0;
      rtc_clk_d = ~rtc_clk_q;
    end
    // Disabled RTC parks low
    if (!rtc_en_i) begin
      cnt_d     = '0;
      rtc_clk_d = 1'b0;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= '0;
      rtc_clk_q <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      rtc_clk_q <= rtc_clk_d;
    end
  end

  assign rtc_clk_o = rtc_clk_q;

endmodule
